/* rw_defines.svh */
// Read/write engine widths
`ifndef RW_DEFINES_SVH
`define RW_DEFINES_SVH

// ---------------------------------------------------------------------------
// Memory side
// ---------------------------------------------------------------------------
// Byte address of a memory request
`define RW_ADDR_W 32
// Memory word and engine packet data
`define RW_DATA_W 32

// ---------------------------------------------------------------------------
// Engine side
// ---------------------------------------------------------------------------
// Packet index into the array
`define RW_INDEX_W 16
// Packets per run
`define RW_COUNT_W 16
// Destination bit on top of the packet index
`define RW_TAG_W (1 + `RW_INDEX_W)
// Reads in flight
`define RW_OUTSTANDING_W 8

`endif

/* rw_pkg.sv */
// Read/write engine types
package rw_pkg;

    // Operation carried in the top bit of the configuration word
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rw_opcode_e;

    // Command on the memory request channel
    typedef enum logic [0:0] {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } mem_cmd_e;

    // Top bit of a memory tag, picks the response consumer
    typedef enum logic [0:0] {
        DEST_CONFIG    = 1'b0,
        DEST_GENERATOR = 1'b1
    } resp_dest_e;

    // Run control of the request generator
    typedef enum logic [2:0] {
        S_IDLE         = 3'd0,
        S_FETCH_CONFIG = 3'd1,
        S_WAIT_CONFIG  = 3'd2,
        S_RUN          = 3'd3,
        S_DONE         = 3'd4
    } gen_state_e;

endpackage : rw_pkg

/* rw_response_router.sv */
// Memory response router
`timescale 1ns/1ps
`include "rw_defines.svh"

module rw_response_router (
    input  logic                  ap_clk,
    input  logic                  areset_read_write_engine,
    input  logic                  mem_resp_valid,
    input  logic [`RW_DATA_W-1:0] mem_resp_data,
    input  logic [`RW_TAG_W-1:0]  mem_resp_tag,
    output logic                  mem_resp_ready,
    output logic                  config_resp_valid,
    output logic [`RW_DATA_W-1:0] config_resp_data,
    input  logic                  config_resp_ready,
    output logic                  gen_resp_valid,
    output logic [`RW_DATA_W-1:0] gen_resp_data,
    output logic [`RW_TAG_W-1:0]  gen_resp_tag,
    input  logic                  gen_resp_ready,
    output logic                  empty
);

    // ------------------------------------------------------------------------
    // One-entry holding register
    // ------------------------------------------------------------------------
    logic                  held_valid;
    logic [`RW_DATA_W-1:0] held_data;
    logic [`RW_TAG_W-1:0]  held_tag;
    rw_pkg::resp_dest_e    held_dest;
    logic                  held_taken;

    // Destination sits in the top tag bit
    assign held_dest = rw_pkg::resp_dest_e'(held_tag[`RW_TAG_W-1]);

    // Only the addressed consumer sees valid
    assign config_resp_valid = held_valid && (held_dest == rw_pkg::DEST_CONFIG);
    assign gen_resp_valid    = held_valid && (held_dest == rw_pkg::DEST_GENERATOR);
    assign config_resp_data  = held_data;
    assign gen_resp_data     = held_data;
    assign gen_resp_tag      = held_tag;

    assign held_taken = (config_resp_valid && config_resp_ready) ||
                        (gen_resp_valid && gen_resp_ready);

    // Accept while empty or while the held entry leaves this cycle
    assign mem_resp_ready = !held_valid || held_taken;
    assign empty          = !held_valid;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            held_valid <= 1'b0;
        end else if (mem_resp_valid && mem_resp_ready) begin
            held_valid <= 1'b1;
        end else if (held_taken) begin
            held_valid <= 1'b0;
        end
    end

    // Payload follows the accepted response
    always_ff @(posedge ap_clk) begin
        if (mem_resp_valid && mem_resp_ready) begin
            held_data <= mem_resp_data;
            held_tag  <= mem_resp_tag;
        end
    end

    // A stalled memory response stays presented and unchanged
    a_resp_held : assert property (@(posedge ap_clk)
        disable iff (areset_read_write_engine)
        mem_resp_valid && !mem_resp_ready |=>
            mem_resp_valid && $stable(mem_resp_data) && $stable(mem_resp_tag))
        else $error("memory response dropped or changed while stalled");

endmodule : rw_response_router

/* rw_configure_memory.sv */
// Engine configuration unit
`timescale 1ns/1ps
`include "rw_defines.svh"

module rw_configure_memory (
    input  logic                  ap_clk,
    input  logic                  areset_read_write_engine,
    input  logic                  config_request,
    input  logic                  config_resp_valid,
    input  logic [`RW_DATA_W-1:0] config_resp_data,
    output logic                  config_resp_ready,
    output logic                  config_valid,
    output rw_pkg::rw_opcode_e    opcode,
    output logic [`RW_ADDR_W-1:0] array_base
);

    // ------------------------------------------------------------------------
    // Configuration word fields
    // ------------------------------------------------------------------------
    rw_pkg::rw_opcode_e    word_opcode;
    logic [`RW_ADDR_W-1:0] word_base;

    // Opcode in the top data bit
    assign word_opcode = rw_pkg::rw_opcode_e'(config_resp_data[`RW_DATA_W-1]);
    // Base in the low bits, zero-extended
    assign word_base = {{(`RW_ADDR_W-`RW_DATA_W+1){1'b0}}, config_resp_data[`RW_DATA_W-2:0]};

    // Single word per run, never stalls the router
    assign config_resp_ready = 1'b1;

    // Valid cleared by a new run, set by its response
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            config_valid <= 1'b0;
        end else if (config_request) begin
            config_valid <= 1'b0;
        end else if (config_resp_valid) begin
            config_valid <= 1'b1;
        end
    end

    // Fields held for the whole run
    always_ff @(posedge ap_clk) begin
        if (config_resp_valid) begin
            opcode     <= word_opcode;
            array_base <= word_base;
        end
    end

    // Exactly one config read per run, so no second response
    a_single_config : assert property (@(posedge ap_clk)
        disable iff (areset_read_write_engine)
        config_resp_valid |-> !config_valid)
        else $error("config response while configuration already valid");

endmodule : rw_configure_memory

/* rw_request_generator.sv */
// Read/write request generator
`timescale 1ns/1ps
`include "rw_defines.svh"

module rw_request_generator (
    input  logic                         ap_clk,
    input  logic                         areset_read_write_engine,
    input  logic                         descriptor_valid,
    input  logic [`RW_ADDR_W-1:0]        descriptor_config_addr,
    input  logic [`RW_COUNT_W-1:0]       descriptor_count,
    output logic                         config_request,
    input  logic                         config_valid,
    input  rw_pkg::rw_opcode_e           opcode,
    input  logic [`RW_ADDR_W-1:0]        array_base,
    input  logic                         engine_in_valid,
    input  logic [`RW_INDEX_W-1:0]       engine_in_index,
    input  logic [`RW_DATA_W-1:0]        engine_in_data,
    output logic                         engine_in_ready,
    output logic                         engine_out_valid,
    output logic [`RW_INDEX_W-1:0]       engine_out_index,
    output logic [`RW_DATA_W-1:0]        engine_out_data,
    input  logic                         engine_out_ready,
    output logic                         mem_req_valid,
    output rw_pkg::mem_cmd_e             mem_req_cmd,
    output logic [`RW_ADDR_W-1:0]        mem_req_addr,
    output logic [`RW_DATA_W-1:0]        mem_req_data,
    output logic [`RW_TAG_W-1:0]         mem_req_tag,
    input  logic                         mem_req_ready,
    input  logic                         gen_resp_valid,
    input  logic [`RW_DATA_W-1:0]        gen_resp_data,
    input  logic [`RW_TAG_W-1:0]         gen_resp_tag,
    output logic                         gen_resp_ready,
    output logic                         run_done
);

    // ------------------------------------------------------------------------
    // Run state
    // ------------------------------------------------------------------------
    rw_pkg::gen_state_e          state;
    logic [`RW_ADDR_W-1:0]       config_addr;
    logic [`RW_COUNT_W-1:0]      count_target;
    logic [`RW_COUNT_W-1:0]      processed;
    logic [`RW_OUTSTANDING_W-1:0] outstanding;

    logic packets_left;
    logic outstanding_full;
    logic packet_fire;
    logic read_issue;
    logic out_fire;
    logic resp_fire;

    // New run only from idle or after the previous one finished
    assign config_request = descriptor_valid &&
                            (state == rw_pkg::S_IDLE || state == rw_pkg::S_DONE);

    assign packets_left     = processed != count_target;
    assign outstanding_full = &outstanding;

    // Packet goes straight through to memory
    assign engine_in_ready = (state == rw_pkg::S_RUN) && packets_left &&
                             !outstanding_full && mem_req_ready;
    assign packet_fire = engine_in_valid && engine_in_ready;
    assign read_issue  = packet_fire && (opcode == rw_pkg::OP_READ);

    // Output register frees on the consumer side
    assign gen_resp_ready = !engine_out_valid || engine_out_ready;
    assign resp_fire      = gen_resp_valid && gen_resp_ready;
    assign out_fire       = engine_out_valid && engine_out_ready;

    assign run_done = state == rw_pkg::S_DONE;

    // ------------------------------------------------------------------------
    // Memory request mux
    // ------------------------------------------------------------------------
    always_comb begin
        mem_req_valid = 1'b0;
        mem_req_cmd   = rw_pkg::CMD_READ;
        mem_req_addr  = config_addr;
        mem_req_data  = '0;
        mem_req_tag   = {rw_pkg::DEST_CONFIG, {`RW_INDEX_W{1'b0}}};
        if (state == rw_pkg::S_FETCH_CONFIG) begin
            // Config word read
            mem_req_valid = 1'b1;
        end else if (state == rw_pkg::S_RUN) begin
            mem_req_valid = engine_in_valid && packets_left && !outstanding_full;
            mem_req_cmd   = (opcode == rw_pkg::OP_READ) ? rw_pkg::CMD_READ : rw_pkg::CMD_WRITE;
            mem_req_addr  = array_base + {{(`RW_ADDR_W-`RW_INDEX_W){1'b0}}, engine_in_index};
            mem_req_data  = engine_in_data;
            // Index rides back in the tag
            mem_req_tag   = {rw_pkg::DEST_GENERATOR, engine_in_index};
        end
    end

    // ------------------------------------------------------------------------
    // FSM and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            state       <= rw_pkg::S_IDLE;
            processed   <= '0;
            outstanding <= '0;
        end else begin
            case (state)
                rw_pkg::S_IDLE, rw_pkg::S_DONE: begin
                    if (config_request) begin
                        processed <= '0;
                        state     <= rw_pkg::S_FETCH_CONFIG;
                    end
                end
                rw_pkg::S_FETCH_CONFIG: begin
                    if (mem_req_ready) begin
                        state <= rw_pkg::S_WAIT_CONFIG;
                    end
                end
                rw_pkg::S_WAIT_CONFIG: begin
                    if (config_valid) begin
                        state <= rw_pkg::S_RUN;
                    end
                end
                rw_pkg::S_RUN: begin
                    if (packet_fire) begin
                        processed <= processed + 1'b1;
                    end
                    // All packets in and every read returned
                    if (!packets_left && outstanding == '0) begin
                        state <= rw_pkg::S_DONE;
                    end
                end
                default: state <= rw_pkg::S_IDLE;
            endcase
            // Read counted until its data leaves on engine_out
            case ({read_issue, out_fire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Descriptor fields kept for the run
    always_ff @(posedge ap_clk) begin
        if (config_request) begin
            config_addr  <= descriptor_config_addr;
            count_target <= descriptor_count;
        end
    end

    // ------------------------------------------------------------------------
    // Read response output register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            engine_out_valid <= 1'b0;
        end else if (resp_fire) begin
            engine_out_valid <= 1'b1;
        end else if (engine_out_ready) begin
            engine_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (resp_fire) begin
            engine_out_index <= gen_resp_tag[`RW_INDEX_W-1:0];
            engine_out_data  <= gen_resp_data;
        end
    end

    // Every returned read was issued by this run
    a_no_underflow : assert property (@(posedge ap_clk)
        disable iff (areset_read_write_engine)
        out_fire |-> outstanding != '0)
        else $error("outstanding read counter underflow");

    // Packets only flow once configured
    a_run_only : assert property (@(posedge ap_clk)
        disable iff (areset_read_write_engine)
        packet_fire |-> config_valid)
        else $error("engine packet accepted without a valid configuration");

endmodule : rw_request_generator

/* engine_read_write.sv */
// Read/write engine top level
`timescale 1ns/1ps
`include "rw_defines.svh"

module engine_read_write (
    input  logic                   ap_clk,
    input  logic                   areset_read_write_engine,
    input  logic                   descriptor_valid,
    input  logic [`RW_ADDR_W-1:0]  descriptor_config_addr,
    input  logic [`RW_COUNT_W-1:0] descriptor_count,
    input  logic                   engine_in_valid,
    input  logic [`RW_INDEX_W-1:0] engine_in_index,
    input  logic [`RW_DATA_W-1:0]  engine_in_data,
    output logic                   engine_in_ready,
    output logic                   engine_out_valid,
    output logic [`RW_INDEX_W-1:0] engine_out_index,
    output logic [`RW_DATA_W-1:0]  engine_out_data,
    input  logic                   engine_out_ready,
    output logic                   mem_req_valid,
    output rw_pkg::mem_cmd_e       mem_req_cmd,
    output logic [`RW_ADDR_W-1:0]  mem_req_addr,
    output logic [`RW_DATA_W-1:0]  mem_req_data,
    output logic [`RW_TAG_W-1:0]   mem_req_tag,
    input  logic                   mem_req_ready,
    input  logic                   mem_resp_valid,
    input  logic [`RW_DATA_W-1:0]  mem_resp_data,
    input  logic [`RW_TAG_W-1:0]   mem_resp_tag,
    output logic                   mem_resp_ready,
    output logic                   done
);

    // ------------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------------
    // Router to configuration unit
    logic                  config_resp_valid;
    logic [`RW_DATA_W-1:0] config_resp_data;
    logic                  config_resp_ready;
    // Router to generator
    logic                  gen_resp_valid;
    logic [`RW_DATA_W-1:0] gen_resp_data;
    logic [`RW_TAG_W-1:0]  gen_resp_tag;
    logic                  gen_resp_ready;
    logic                  router_empty;
    // Configuration unit to generator
    logic                  config_request;
    logic                  config_valid;
    rw_pkg::rw_opcode_e    opcode;
    logic [`RW_ADDR_W-1:0] array_base;
    logic                  run_done;

    rw_response_router i_rw_response_router (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .mem_resp_valid          (mem_resp_valid),
        .mem_resp_data           (mem_resp_data),
        .mem_resp_tag            (mem_resp_tag),
        .mem_resp_ready          (mem_resp_ready),
        .config_resp_valid       (config_resp_valid),
        .config_resp_data        (config_resp_data),
        .config_resp_ready       (config_resp_ready),
        .gen_resp_valid          (gen_resp_valid),
        .gen_resp_data           (gen_resp_data),
        .gen_resp_tag            (gen_resp_tag),
        .gen_resp_ready          (gen_resp_ready),
        .empty                   (router_empty)
    );

    rw_configure_memory i_rw_configure_memory (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .config_request          (config_request),
        .config_resp_valid       (config_resp_valid),
        .config_resp_data        (config_resp_data),
        .config_resp_ready       (config_resp_ready),
        .config_valid            (config_valid),
        .opcode                  (opcode),
        .array_base              (array_base)
    );

    rw_request_generator i_rw_request_generator (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .descriptor_valid        (descriptor_valid),
        .descriptor_config_addr  (descriptor_config_addr),
        .descriptor_count        (descriptor_count),
        .config_request          (config_request),
        .config_valid            (config_valid),
        .opcode                  (opcode),
        .array_base              (array_base),
        .engine_in_valid         (engine_in_valid),
        .engine_in_index         (engine_in_index),
        .engine_in_data          (engine_in_data),
        .engine_in_ready         (engine_in_ready),
        .engine_out_valid        (engine_out_valid),
        .engine_out_index        (engine_out_index),
        .engine_out_data         (engine_out_data),
        .engine_out_ready        (engine_out_ready),
        .mem_req_valid           (mem_req_valid),
        .mem_req_cmd             (mem_req_cmd),
        .mem_req_addr            (mem_req_addr),
        .mem_req_data            (mem_req_data),
        .mem_req_tag             (mem_req_tag),
        .mem_req_ready           (mem_req_ready),
        .gen_resp_valid          (gen_resp_valid),
        .gen_resp_data           (gen_resp_data),
        .gen_resp_tag            (gen_resp_tag),
        .gen_resp_ready          (gen_resp_ready),
        .run_done                (run_done)
    );

    // ------------------------------------------------------------------------
    // Done flag
    // ------------------------------------------------------------------------
    // Run finished and nothing left in the router
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            done <= 1'b0;
        end else begin
            done <= run_done && router_empty;
        end
    end

endmodule : engine_read_write

/* tb_engine_read_write.sv */
// Read/write engine testbench
`timescale 1ns/1ps
`include "rw_defines.svh"

module tb_engine_read_write;

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------
    logic                   ap_clk;
    logic                   areset_read_write_engine;
    logic                   descriptor_valid;
    logic [`RW_ADDR_W-1:0]  descriptor_config_addr;
    logic [`RW_COUNT_W-1:0] descriptor_count;
    logic                   engine_in_valid;
    logic [`RW_INDEX_W-1:0] engine_in_index;
    logic [`RW_DATA_W-1:0]  engine_in_data;
    logic                   engine_in_ready;
    logic                   engine_out_valid;
    logic [`RW_INDEX_W-1:0] engine_out_index;
    logic [`RW_DATA_W-1:0]  engine_out_data;
    logic                   engine_out_ready;
    logic                   mem_req_valid;
    rw_pkg::mem_cmd_e       mem_req_cmd;
    logic [`RW_ADDR_W-1:0]  mem_req_addr;
    logic [`RW_DATA_W-1:0]  mem_req_data;
    logic [`RW_TAG_W-1:0]   mem_req_tag;
    logic                   mem_req_ready;
    logic                   mem_resp_valid;
    logic [`RW_DATA_W-1:0]  mem_resp_data;
    logic [`RW_TAG_W-1:0]   mem_resp_tag;
    logic                   mem_resp_ready;
    logic                   done;

    // ------------------------------------------------------------------------
    // Stimulus table, one row per run
    // ------------------------------------------------------------------------
    // Plain reads come back as address XOR this constant
    localparam logic [`RW_DATA_W-1:0] read_xor = 32'ha5c3_0f5a;

    logic [`RW_ADDR_W-1:0]  row_config_addr [4] = '{
        32'h0000_0100, 32'h0000_0240, 32'h0000_0380, 32'h0000_04c0
    };
    rw_pkg::rw_opcode_e     row_opcode [4] = '{
        rw_pkg::OP_READ, rw_pkg::OP_WRITE, rw_pkg::OP_READ, rw_pkg::OP_WRITE
    };
    logic [`RW_ADDR_W-1:0]  row_base [4] = '{
        32'h0001_0000, 32'h0002_4000, 32'h7fff_0000, 32'h0000_8000
    };
    logic [`RW_COUNT_W-1:0] row_count [4] = '{16'd5, 16'd3, 16'd8, 16'd6};
    // Index/data seed, row 2 wraps the 16-bit index
    logic [31:0]            row_seed [4] = '{
        32'h0000_1234, 32'h0000_0abc, 32'h0000_fff0, 32'h0000_0042
    };

    // Scoreboard
    rw_pkg::mem_cmd_e       exp_cmd [$];
    logic [`RW_ADDR_W-1:0]  exp_addr [$];
    logic [`RW_DATA_W-1:0]  exp_data [$];
    logic [`RW_TAG_W-1:0]   exp_tag [$];
    logic [`RW_DATA_W-1:0]  exp_out [logic [`RW_INDEX_W-1:0]];
    // Memory responses in flight and packets still to send
    logic [`RW_DATA_W-1:0]  resp_data_q [$];
    logic [`RW_TAG_W-1:0]   resp_tag_q [$];
    logic [`RW_INDEX_W-1:0] pkt_index_q [$];
    logic [`RW_DATA_W-1:0]  pkt_data_q [$];

    logic [31:0] rng;
    int          cur_row;
    logic        row_is_write;
    logic        config_returned;
    int          accepted;
    int          errors;
    int          timeouts;

    engine_read_write i_engine_read_write (.*);

    initial begin
        ap_clk = 1'b0;
        forever begin
            #2 ap_clk = ~ap_clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Opcode on top, base in the low 31 bits
    function automatic logic [`RW_DATA_W-1:0] config_word(input int r);
        return {row_opcode[r], row_base[r][`RW_DATA_W-2:0]};
    endfunction

    task automatic log_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_simulation();
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // Queue the packets of one row and everything they should cause
    task automatic load_row(input int row);
        int                     i;
        logic [`RW_INDEX_W-1:0] idx;
        logic [`RW_DATA_W-1:0]  dat;
        logic [`RW_ADDR_W-1:0]  addr;
        cur_row         = row;
        row_is_write    = row_opcode[row] == rw_pkg::OP_WRITE;
        accepted        = 0;
        config_returned = 1'b0;
        exp_out.delete();
        // Config fetch first
        exp_cmd.push_back(rw_pkg::CMD_READ);
        exp_addr.push_back(row_config_addr[row]);
        exp_data.push_back('0);
        exp_tag.push_back({rw_pkg::DEST_CONFIG, {`RW_INDEX_W{1'b0}}});
        for (i = 0; i < int'(row_count[row]); i++) begin
            idx  = row_seed[row][`RW_INDEX_W-1:0] + 16'(5 * i);
            dat  = xorshift(row_seed[row] + 32'(i));
            addr = row_base[row] + {{(`RW_ADDR_W-`RW_INDEX_W){1'b0}}, idx};
            pkt_index_q.push_back(idx);
            pkt_data_q.push_back(dat);
            if (row_is_write) begin
                exp_cmd.push_back(rw_pkg::CMD_WRITE);
            end else begin
                exp_cmd.push_back(rw_pkg::CMD_READ);
                exp_out[idx] = addr ^ read_xor;
            end
            exp_addr.push_back(addr);
            exp_data.push_back(dat);
            exp_tag.push_back({rw_pkg::DEST_GENERATOR, idx});
        end
    endtask

    task automatic wait_for_done(input int row, input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (done !== level && cycles < limit) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (done !== level) begin
            $display("Timeout in row %0d: done never went to %0b within %0d cycles",
                     row, level, limit);
            timeouts++;
        end
    endtask

    // Everything of the row must be through once done is up
    task automatic check_row_end(input int row);
        if (pkt_index_q.size() != 0 || accepted != int'(row_count[row])) begin
            log_mismatch($sformatf("row %0d done after %0d of %0d packets",
                                   row, accepted, row_count[row]));
        end
        if (exp_cmd.size() != 0 || resp_data_q.size() != 0) begin
            log_mismatch($sformatf("row %0d done with %0d requests missing",
                                   row, exp_cmd.size()));
        end
        if (exp_out.size() != 0) begin
            log_mismatch($sformatf("row %0d done with %0d read results missing",
                                   row, exp_out.size()));
        end
    endtask

    // ------------------------------------------------------------------------
    // Memory model, packet source and monitors
    // ------------------------------------------------------------------------
    initial begin
        logic [`RW_DATA_W-1:0] rd_word;
        rng              = 32'd27027;
        mem_req_ready    = 1'b0;
        engine_out_ready = 1'b0;
        mem_resp_valid   = 1'b0;
        mem_resp_data    = '0;
        mem_resp_tag     = '0;
        engine_in_valid  = 1'b0;
        engine_in_index  = '0;
        engine_in_data   = '0;
        forever begin
            @(posedge ap_clk);
            rng = xorshift(rng);
            // Requests compared in issue order
            if (mem_req_valid && mem_req_ready) begin
                if (exp_cmd.size() == 0) begin
                    log_mismatch($sformatf("unexpected request at %h", mem_req_addr));
                end else begin
                    if (mem_req_cmd != exp_cmd[0] || mem_req_addr != exp_addr[0]) begin
                        log_mismatch($sformatf("request cmd %0d addr %h, expected %0d %h",
                                               mem_req_cmd, mem_req_addr,
                                               exp_cmd[0], exp_addr[0]));
                    end
                    if (exp_cmd[0] == rw_pkg::CMD_WRITE && mem_req_data != exp_data[0]) begin
                        log_mismatch($sformatf("write data %h, expected %h",
                                               mem_req_data, exp_data[0]));
                    end
                    if (exp_cmd[0] == rw_pkg::CMD_READ &&
                        (mem_req_tag[`RW_TAG_W-1] != exp_tag[0][`RW_TAG_W-1] ||
                         (exp_tag[0][`RW_TAG_W-1] == rw_pkg::DEST_GENERATOR &&
                          mem_req_tag != exp_tag[0]))) begin
                        log_mismatch($sformatf("read tag %h, expected %h",
                                               mem_req_tag, exp_tag[0]));
                    end
                    exp_cmd.delete(0);
                    exp_addr.delete(0);
                    exp_data.delete(0);
                    exp_tag.delete(0);
                end
                if (mem_req_cmd == rw_pkg::CMD_READ) begin
                    if (mem_req_addr == row_config_addr[cur_row]) begin
                        rd_word = config_word(cur_row);
                    end else begin
                        rd_word = mem_req_addr ^ read_xor;
                    end
                    resp_data_q.push_back(rd_word);
                    resp_tag_q.push_back(mem_req_tag);
                end
            end
            if (mem_resp_valid && mem_resp_ready) begin
                if (mem_resp_tag[`RW_TAG_W-1] == rw_pkg::DEST_CONFIG) begin
                    config_returned = 1'b1;
                end
                resp_data_q.delete(0);
                resp_tag_q.delete(0);
            end
            if (engine_in_valid && engine_in_ready) begin
                if (!config_returned) begin
                    log_mismatch("packet accepted before the config response");
                end
                accepted++;
                pkt_index_q.delete(0);
                pkt_data_q.delete(0);
            end
            if (engine_out_valid && row_is_write) begin
                log_mismatch("engine_out valid during a write run");
            end
            if (engine_out_valid && engine_out_ready) begin
                if (!exp_out.exists(engine_out_index)) begin
                    log_mismatch($sformatf("unexpected or repeated index %h",
                                           engine_out_index));
                end else begin
                    if (engine_out_data != exp_out[engine_out_index]) begin
                        log_mismatch($sformatf("index %h data %h, expected %h",
                                               engine_out_index, engine_out_data,
                                               exp_out[engine_out_index]));
                    end
                    exp_out.delete(engine_out_index);
                end
            end
            // Next cycle, ready high about three quarters of the time
            mem_req_ready    <= rng[0] | rng[1];
            engine_out_ready <= rng[2] | rng[3];
            mem_resp_valid   <= resp_data_q.size() != 0;
            engine_in_valid  <= pkt_index_q.size() != 0;
            if (resp_data_q.size() != 0) begin
                mem_resp_data <= resp_data_q[0];
                mem_resp_tag  <= resp_tag_q[0];
            end
            if (pkt_index_q.size() != 0) begin
                engine_in_index <= pkt_index_q[0];
                engine_in_data  <= pkt_data_q[0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Run sequence
    // ------------------------------------------------------------------------
    initial begin
        int row;
        errors                   = 0;
        timeouts                 = 0;
        cur_row                  = 0;
        row_is_write             = 1'b0;
        config_returned          = 1'b0;
        accepted                 = 0;
        areset_read_write_engine = 1'b1;
        descriptor_valid         = 1'b0;
        descriptor_config_addr   = '0;
        descriptor_count         = '0;
        repeat (3) @(posedge ap_clk);
        areset_read_write_engine <= 1'b0;
        @(posedge ap_clk);
        if (done || engine_out_valid || mem_req_valid || engine_in_ready || !mem_resp_ready) begin
            log_mismatch("outputs not idle after reset");
        end
        for (row = 0; row < 4 && timeouts == 0; row++) begin
            @(negedge ap_clk);
            load_row(row);
            @(posedge ap_clk);
            descriptor_valid       <= 1'b1;
            descriptor_config_addr <= row_config_addr[row];
            descriptor_count       <= row_count[row];
            @(posedge ap_clk);
            descriptor_valid <= 1'b0;
            // Old done falls first, then the new one rises
            wait_for_done(row, 1'b0, 8);
            if (timeouts == 0) begin
                wait_for_done(row, 1'b1, 2000);
            end
            if (timeouts == 0) begin
                check_row_end(row);
                repeat (3) begin
                    @(posedge ap_clk);
                    if (!done) begin
                        log_mismatch($sformatf("done dropped early in row %0d", row));
                    end
                end
            end
        end
        finish_simulation();
    end

endmodule : tb_engine_read_write

/* files.f */
+incdir+.
rw_pkg.sv
rw_response_router.sv
rw_configure_memory.sv
rw_request_generator.sv
engine_read_write.sv
tb_engine_read_write.sv

/* run.sh */
#!/usr/bin/env bash
# Build the engine testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f files.f --top-module tb_engine_read_write \
    || { echo "verilator build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_engine_read_write)"
echo "$sim_out"
echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1
